/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP := rv_core_tb
FLIST := flist.f
BUILD_DIR := obj_dir
SIM := $(BUILD_DIR)/V$(TOP)
LOG := sim.log
SOURCES := $(shell cat $(FLIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/clock_gen.sv */
`timescale 1ns/1ns

module clock_gen (
	output logic clock,
	output logic reset
);

	localparam int PERIOD_NS = 40;
	localparam int RESET_CYCLES = 16;

	initial begin
		clock = 1'b0;
		forever #(PERIOD_NS / 2) clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0; // released away from the sampling edge
	end

endmodule

/* bench/rv_core_assert.sv */
`timescale 1ns/1ns

module rv_core_assert (
	input logic clock,
	input logic reset,
	input logic imem_valid_i,
	input rv_pkg::addr_t imem_addr_i,
	input logic imem_ready_i,
	input logic commit_valid_i
);

	logic in_flight_q;

	// set by a fetch, cleared when that instruction retires
	always_ff @(posedge clock) begin
		if (reset) begin
			in_flight_q <= 1'b0;
		end else if (imem_valid_i && imem_ready_i) begin
			in_flight_q <= 1'b1;
		end else if (commit_valid_i) begin
			in_flight_q <= 1'b0;
		end
	end

	a_imem_hold: assert property (@(posedge clock) disable iff (reset)
		imem_valid_i && !imem_ready_i |=> imem_valid_i && $stable(imem_addr_i))
		else $error("imem request dropped or changed before ready");

	a_commit_pulse: assert property (@(posedge clock) disable iff (reset)
		commit_valid_i |=> !commit_valid_i)
		else $error("commit valid high for two cycles in a row");

	a_single_issue: assert property (@(posedge clock) disable iff (reset)
		in_flight_q |-> !(imem_valid_i && imem_ready_i))
		else $error("second fetch before the previous instruction retired");

endmodule

bind rv_core rv_core_assert i_rv_core_assert (
	.clock          (clock),
	.reset          (reset),
	.imem_valid_i   (imem_valid_o),
	.imem_addr_i    (imem_addr_o),
	.imem_ready_i   (imem_ready_i),
	.commit_valid_i (commit_valid_o)
);

/* bench/rv_core_tb.sv */
`timescale 1ns/1ns

module rv_core_tb;

	localparam int CLOCK_NS = 40;
	localparam int RESET_CYCLES = 16;
	localparam int N_COMMITS = 600;
	localparam int CYCLES_PER_COMMIT = 8; // 5 cycles plus up to 3 wait states
	localparam int WATCHDOG_NS = (N_COMMITS * CYCLES_PER_COMMIT + RESET_CYCLES) * CLOCK_NS;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic clock;
	logic reset;
	logic imem_valid_o;
	rv_pkg::addr_t imem_addr_o;
	logic imem_ready_i;
	rv_pkg::inst_t imem_data_i;
	logic commit_valid_o;
	rv_pkg::addr_t commit_pc_o;
	rv_pkg::inst_t commit_inst_o;
	logic commit_we_o;
	rv_pkg::reg_addr_t commit_rd_o;
	rv_pkg::xlen_t commit_data_o;

	logic [31:0] lfsr_q = 32'ha93b_baa1;
	rv_pkg::inst_t prog [0:255];
	rv_pkg::xlen_t model_regs [0:31];

	clock_gen i_clock_gen (
		.clock (clock),
		.reset (reset)
	);

	rv_core i_rv_core (
		.clock          (clock),
		.reset          (reset),
		.imem_valid_o   (imem_valid_o),
		.imem_addr_o    (imem_addr_o),
		.imem_ready_i   (imem_ready_i),
		.imem_data_i    (imem_data_i),
		.commit_valid_o (commit_valid_o),
		.commit_pc_o    (commit_pc_o),
		.commit_inst_o  (commit_inst_o),
		.commit_we_o    (commit_we_o),
		.commit_rd_o    (commit_rd_o),
		.commit_data_o  (commit_data_o)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
	endfunction

	// one lfsr step per bit, first bit taken ends up as the msb
	function automatic logic [31:0] rand_bits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int k = 0; k < count; k++) begin
			bits = {bits[30:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
		return bits;
	endfunction

	task automatic stop_run();
		$display("TESTS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_addr(input string name, input rv_pkg::addr_t got,
			input rv_pkg::addr_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_data(input string name, input rv_pkg::xlen_t got,
			input rv_pkg::xlen_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_inst(input string name, input rv_pkg::inst_t got,
			input rv_pkg::inst_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_reg(input string name, input rv_pkg::reg_addr_t got,
			input rv_pkg::reg_addr_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
			stop_run();
		end
	endtask

	// forward-only control flow, so the run ends in the self loop at word 255
	task automatic build_program();
		logic [31:0] r;
		logic [31:0] q;
		logic [2:0] kind;
		logic [2:0] f3;
		logic [3:0] fwd;
		logic [6:0] f7;
		logic [11:0] imm12;
		logic [12:0] boff;
		logic [20:0] joff;
		rv_pkg::reg_addr_t rd;
		rv_pkg::reg_addr_t rs1;
		rv_pkg::reg_addr_t rs2;
		int i;
		i = 0;
		while (i < 255) begin
			r = rand_bits(32);
			q = rand_bits(20);
			kind = r[2:0];
			rd = r[7:3];
			rs1 = r[12:8];
			rs2 = r[17:13];
			f3 = r[20:18];
			f7 = {1'b0, r[21], 5'b0};
			fwd = {1'b0, r[24:22]} + 4'd1; // 1 to 8 words ahead
			boff = {7'b0, fwd, 2'b00};
			joff = {15'b0, fwd, 2'b00};
			imm12 = q[11:0];
			if (i >= 240 && kind >= 3'd5) begin
				kind = {1'b0, r[26:25]}; // no jumps near the end
			end
			case (kind)
				3'd0, 3'd1: begin
					if (f3 == 3'b001) begin
						imm12 = {7'b0, q[4:0]};
					end else if (f3 == 3'b101) begin
						imm12 = {f7, q[4:0]};
					end
					prog[i] = {imm12, rs1, f3, rd, rv_pkg::OPC_OP_IMM};
				end
				3'd2: begin
					if (f3 != 3'b000 && f3 != 3'b101) begin
						f7 = 7'b0;
					end
					prog[i] = {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
				end
				3'd3: prog[i] = {q[19:0], rd, rv_pkg::OPC_LUI};
				3'd4: prog[i] = {q[19:0], rd, rv_pkg::OPC_AUIPC};
				3'd5: begin
					if (f3[2:1] == 2'b01) begin
						f3[2:1] = 2'b00; // funct3 010 and 011 are not branches
					end
					prog[i] = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11],
						rv_pkg::OPC_BRANCH};
				end
				3'd6: begin
					prog[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, rv_pkg::OPC_JAL};
				end
				default: begin
					prog[i] = {20'h0, rs1, rv_pkg::OPC_LUI}; // base register set to zero
					i++;
					imm12 = 12'((i + int'(fwd)) * 4) | {11'b0, r[27]};
					prog[i] = {imm12, rs1, 3'b000, rd, rv_pkg::OPC_JALR};
				end
			endcase
			i++;
		end
		prog[255] = {20'h0, 5'd0, rv_pkg::OPC_JAL};
	endtask

	// executes one instruction on model_regs without writing them
	function automatic void ref_exec(input rv_pkg::addr_t pc, input rv_pkg::inst_t inst,
			output logic we, output rv_pkg::reg_addr_t rd, output rv_pkg::xlen_t data,
			output rv_pkg::addr_t npc);
		rv_pkg::xlen_t a;
		rv_pkg::xlen_t b;
		rv_pkg::xlen_t y;
		rv_pkg::xlen_t imm_i;
		rv_pkg::xlen_t imm_b;
		rv_pkg::xlen_t imm_j;
		rv_pkg::xlen_t imm_u;
		logic [2:0] f3;
		logic is_reg;
		logic cond;
		a = model_regs[inst[19:15]];
		b = model_regs[inst[24:20]];
		imm_i = {{20{inst[31]}}, inst[31:20]};
		imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
		imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
		imm_u = {inst[31:12], 12'b0};
		f3 = inst[14:12];
		is_reg = (inst[6:0] == rv_pkg::OPC_OP);
		y = is_reg ? b : imm_i;
		rd = inst[11:7];
		we = 1'b0;
		data = '0;
		cond = 1'b0;
		npc = pc + 32'd4;
		case (inst[6:0])
			rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM: begin
				we = 1'b1;
				case (f3)
					3'b000: data = (is_reg && inst[30]) ? a - y : a + y;
					3'b001: data = a << y[4:0];
					3'b010: data = {31'b0, $signed(a) < $signed(y)};
					3'b011: data = {31'b0, a < y};
					3'b100: data = a ^ y;
					3'b101: begin
						if (inst[30]) begin
							data = $signed(a) >>> y[4:0];
						end else begin
							data = a >> y[4:0];
						end
					end
					3'b110: data = a | y;
					default: data = a & y;
				endcase
			end
			rv_pkg::OPC_LUI: begin
				we = 1'b1;
				data = imm_u;
			end
			rv_pkg::OPC_AUIPC: begin
				we = 1'b1;
				data = pc + imm_u;
			end
			rv_pkg::OPC_JAL: begin
				we = 1'b1;
				data = pc + 32'd4;
				npc = pc + imm_j;
			end
			rv_pkg::OPC_JALR: begin
				we = 1'b1;
				data = pc + 32'd4;
				npc = (a + imm_i) & ~32'd1;
			end
			rv_pkg::OPC_BRANCH: begin
				case (f3)
					3'b000: cond = (a == b);
					3'b001: cond = (a != b);
					3'b100: cond = ($signed(a) < $signed(b));
					3'b101: cond = ($signed(a) >= $signed(b));
					3'b110: cond = (a < b);
					3'b111: cond = (a >= b);
					default: cond = 1'b0;
				endcase
				if (cond) begin
					npc = pc + imm_b;
				end
			end
			default: ;
		endcase
		if (rd == 5'd0) begin
			we = 1'b0;
		end
	endfunction

	// instruction memory with 0 to 3 wait states per request
	initial begin : memory_model
		logic [31:0] r;
		logic pending;
		int wait_left;
		imem_ready_i = 1'b0;
		imem_data_i = '0;
		pending = 1'b0;
		wait_left = 0;
		forever begin
			@(negedge clock);
			if (imem_valid_o !== 1'b1) begin
				pending = 1'b0;
				imem_ready_i <= 1'b0;
			end else begin
				if (!pending) begin
					pending = 1'b1;
					r = rand_bits(2);
					wait_left = int'(r[1:0]);
				end else if (wait_left > 0) begin
					wait_left--;
				end
				if (wait_left == 0) begin
					imem_ready_i <= 1'b1;
					imem_data_i <= prog[imem_addr_o[9:2]];
				end
			end
		end
	end

	initial begin : compare_commits
		rv_pkg::addr_t exp_pc;
		rv_pkg::addr_t exp_npc;
		rv_pkg::inst_t exp_inst;
		rv_pkg::reg_addr_t exp_rd;
		rv_pkg::xlen_t exp_data;
		logic exp_we;
		int commits;
		for (int k = 0; k < 32; k++) begin
			model_regs[k] = '0;
		end
		build_program();
		exp_pc = rv_pkg::RESET_PC;
		commits = 0;
		wait (reset === 1'b0);
		while (commits < N_COMMITS) begin
			@(negedge clock);
			if (imem_valid_o === 1'b1) begin
				check_addr("imem_addr_o", imem_addr_o, exp_pc); // fetch of the next pc
			end
			if (commit_valid_o === 1'b1) begin
				exp_inst = prog[exp_pc[9:2]];
				ref_exec(exp_pc, exp_inst, exp_we, exp_rd, exp_data, exp_npc);
				check_addr("commit_pc_o", commit_pc_o, exp_pc);
				check_inst("commit_inst_o", commit_inst_o, exp_inst);
				check_bit("commit_we_o", commit_we_o, exp_we);
				if (exp_we) begin
					check_reg("commit_rd_o", commit_rd_o, exp_rd);
					check_data("commit_data_o", commit_data_o, exp_data);
					model_regs[exp_rd] = exp_data;
				end
				exp_pc = exp_npc;
				commits++;
			end
		end
		$display("TESTS PASSED");
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("timeout: %0d commits not reached by %0t", N_COMMITS, $time);
		stop_run();
	end

endmodule

/* flist.f */
hdl/rv_pkg.sv
hdl/fetch_decode_if.sv
hdl/decode_execute_if.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/reg_file.sv
hdl/execute_unit.sv
hdl/rv_core.sv
bench/clock_gen.sv
bench/rv_core_assert.sv
bench/rv_core_tb.sv

/* hdl/decode_execute_if.sv */
`timescale 1ns/1ns

interface decode_execute_if;

	logic valid;
	logic ready;
	rv_pkg::addr_t pc;
	rv_pkg::inst_t inst; // only for the commit record
	rv_pkg::xlen_t rs1_val;
	rv_pkg::xlen_t rs2_val;
	rv_pkg::xlen_t imm;
	rv_pkg::reg_addr_t rd;
	logic rd_we;
	rv_pkg::alu_op_e alu_op;
	rv_pkg::br_op_e br_op;
	rv_pkg::src_a_e src_a_sel;
	logic src_b_is_imm;

	modport source (
		output valid, pc, inst, rs1_val, rs2_val, imm, rd, rd_we,
		output alu_op, br_op, src_a_sel, src_b_is_imm,
		input ready
	);

	modport sink (
		input valid, pc, inst, rs1_val, rs2_val, imm, rd, rd_we,
		input alu_op, br_op, src_a_sel, src_b_is_imm,
		output ready
	);

endinterface

/* hdl/decode_unit.sv */
`timescale 1ns/1ns

module decode_unit (
	input logic clock,
	input logic reset,
	fetch_decode_if.sink fd,
	decode_execute_if.source de,
	output rv_pkg::reg_addr_t rs1_addr_o,
	output rv_pkg::reg_addr_t rs2_addr_o,
	input rv_pkg::xlen_t rs1_val_i,
	input rv_pkg::xlen_t rs2_val_i
);

	logic held_q;
	rv_pkg::addr_t pc_q;
	rv_pkg::inst_t inst_q;
	logic advance;
	rv_pkg::opcode_t opcode;
	logic [2:0] funct3;
	rv_pkg::reg_addr_t rd;
	rv_pkg::xlen_t imm;
	rv_pkg::alu_op_e alu_op;
	rv_pkg::br_op_e br_op;
	rv_pkg::src_a_e src_a_sel;
	logic src_b_is_imm;
	logic rd_we;

	// alt is inst[30], sub only exists in the register form
	function automatic rv_pkg::alu_op_e alu_from_funct(input logic [2:0] f3,
			input logic alt, input logic is_reg);
		case (f3)
			3'b000: return (alt && is_reg) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
			3'b001: return rv_pkg::ALU_SLL;
			3'b010: return rv_pkg::ALU_SLT;
			3'b011: return rv_pkg::ALU_SLTU;
			3'b100: return rv_pkg::ALU_XOR;
			3'b101: return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
			3'b110: return rv_pkg::ALU_OR;
			default: return rv_pkg::ALU_AND;
		endcase
	endfunction

	assign advance = held_q && (!de.valid || de.ready);
	assign fd.ready = !held_q || advance;

	assign opcode = inst_q[6:0];
	assign funct3 = inst_q[14:12];
	assign rd = inst_q[11:7];
	assign rs1_addr_o = inst_q[19:15];
	assign rs2_addr_o = inst_q[24:20];

	always_comb begin
		imm = {{20{inst_q[31]}}, inst_q[31:20]}; // I-type
		alu_op = rv_pkg::ALU_ADD;
		br_op = rv_pkg::BR_NONE;
		src_a_sel = rv_pkg::SRC_A_RS1;
		src_b_is_imm = 1'b1;
		rd_we = 1'b0;
		case (opcode)
			rv_pkg::OPC_OP: begin
				alu_op = alu_from_funct(funct3, inst_q[30], 1'b1);
				src_b_is_imm = 1'b0;
				rd_we = 1'b1;
			end
			rv_pkg::OPC_OP_IMM: begin
				alu_op = alu_from_funct(funct3, inst_q[30], 1'b0);
				rd_we = 1'b1;
			end
			rv_pkg::OPC_LUI: begin
				imm = {inst_q[31:12], 12'b0};
				alu_op = rv_pkg::ALU_PASS_B;
				rd_we = 1'b1;
			end
			rv_pkg::OPC_AUIPC: begin
				imm = {inst_q[31:12], 12'b0};
				src_a_sel = rv_pkg::SRC_A_PC;
				rd_we = 1'b1;
			end
			rv_pkg::OPC_JAL: begin
				imm = {{12{inst_q[31]}}, inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};
				src_a_sel = rv_pkg::SRC_A_PC; // alu forms the target
				br_op = rv_pkg::BR_JAL;
				rd_we = 1'b1;
			end
			rv_pkg::OPC_JALR: begin
				br_op = rv_pkg::BR_JALR;
				rd_we = 1'b1;
			end
			rv_pkg::OPC_BRANCH: begin
				imm = {{20{inst_q[31]}}, inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
				src_a_sel = rv_pkg::SRC_A_PC;
				case (funct3)
					3'b000: br_op = rv_pkg::BR_EQ;
					3'b001: br_op = rv_pkg::BR_NE;
					3'b100: br_op = rv_pkg::BR_LT;
					3'b101: br_op = rv_pkg::BR_GE;
					3'b110: br_op = rv_pkg::BR_LTU;
					3'b111: br_op = rv_pkg::BR_GEU;
					default: br_op = rv_pkg::BR_NONE; // falls through
				endcase
			end
			default: ; // unknown, retires as a no-op
		endcase
		if (rd == '0) begin
			rd_we = 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			held_q <= 1'b0;
			de.valid <= 1'b0;
		end else begin
			if (fd.valid && fd.ready) begin
				held_q <= 1'b1;
			end else if (advance) begin
				held_q <= 1'b0;
			end

			if (advance) begin
				de.valid <= 1'b1;
			end else if (de.ready) begin
				de.valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (fd.valid && fd.ready) begin
			pc_q <= fd.pc;
			inst_q <= fd.inst;
		end
		if (advance) begin
			de.pc <= pc_q;
			de.inst <= inst_q;
			de.rs1_val <= rs1_val_i;
			de.rs2_val <= rs2_val_i;
			de.imm <= imm;
			de.rd <= rd;
			de.rd_we <= rd_we;
			de.alu_op <= alu_op;
			de.br_op <= br_op;
			de.src_a_sel <= src_a_sel;
			de.src_b_is_imm <= src_b_is_imm;
		end
	end

endmodule

/* hdl/execute_unit.sv */
`timescale 1ns/1ns

module execute_unit (
	input logic clock,
	input logic reset,
	decode_execute_if.sink de,
	output logic commit_valid_o,
	output rv_pkg::addr_t commit_pc_o,
	output rv_pkg::inst_t commit_inst_o,
	output logic commit_we_o,
	output rv_pkg::reg_addr_t commit_rd_o,
	output rv_pkg::xlen_t commit_data_o,
	output rv_pkg::addr_t next_pc_o
);

	logic accept;
	logic taken;
	logic is_jump;
	logic [4:0] shamt;
	rv_pkg::xlen_t op_a;
	rv_pkg::xlen_t op_b;
	rv_pkg::xlen_t alu_res;
	rv_pkg::xlen_t wb_data;
	rv_pkg::addr_t pc_plus4;
	rv_pkg::addr_t target;
	rv_pkg::addr_t pc_next;

	assign de.ready = 1'b1; // commit port cannot stall
	assign accept = de.valid && de.ready;

	assign op_a = (de.src_a_sel == rv_pkg::SRC_A_PC) ? de.pc : de.rs1_val;
	assign op_b = de.src_b_is_imm ? de.imm : de.rs2_val;
	assign shamt = op_b[4:0];

	always_comb begin
		case (de.alu_op)
			rv_pkg::ALU_SUB: alu_res = op_a - op_b;
			rv_pkg::ALU_SLL: alu_res = op_a << shamt;
			rv_pkg::ALU_SLT: alu_res = {{(rv_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			rv_pkg::ALU_SLTU: alu_res = {{(rv_pkg::XLEN-1){1'b0}}, op_a < op_b};
			rv_pkg::ALU_XOR: alu_res = op_a ^ op_b;
			rv_pkg::ALU_SRL: alu_res = op_a >> shamt;
			rv_pkg::ALU_SRA: alu_res = $signed(op_a) >>> shamt;
			rv_pkg::ALU_OR: alu_res = op_a | op_b;
			rv_pkg::ALU_AND: alu_res = op_a & op_b;
			rv_pkg::ALU_PASS_B: alu_res = op_b;
			default: alu_res = op_a + op_b; // also branch and jump targets
		endcase
	end

	always_comb begin
		case (de.br_op)
			rv_pkg::BR_EQ: taken = (de.rs1_val == de.rs2_val);
			rv_pkg::BR_NE: taken = (de.rs1_val != de.rs2_val);
			rv_pkg::BR_LT: taken = ($signed(de.rs1_val) < $signed(de.rs2_val));
			rv_pkg::BR_GE: taken = ($signed(de.rs1_val) >= $signed(de.rs2_val));
			rv_pkg::BR_LTU: taken = (de.rs1_val < de.rs2_val);
			rv_pkg::BR_GEU: taken = (de.rs1_val >= de.rs2_val);
			rv_pkg::BR_JAL, rv_pkg::BR_JALR: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign is_jump = (de.br_op == rv_pkg::BR_JAL) || (de.br_op == rv_pkg::BR_JALR);
	assign pc_plus4 = de.pc + rv_pkg::INST_BYTES;
	assign target = (de.br_op == rv_pkg::BR_JALR) ? {alu_res[31:1], 1'b0} : alu_res;
	assign pc_next = taken ? target : pc_plus4;
	assign wb_data = is_jump ? pc_plus4 : alu_res; // link value

	always_ff @(posedge clock) begin
		if (reset) begin
			commit_valid_o <= 1'b0;
			commit_we_o <= 1'b0;
		end else begin
			commit_valid_o <= accept;
			commit_we_o <= accept && de.rd_we; // doubles as the regfile write enable
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			commit_pc_o <= de.pc;
			commit_inst_o <= de.inst;
			commit_rd_o <= de.rd;
			commit_data_o <= wb_data;
			next_pc_o <= pc_next;
		end
	end

endmodule

/* hdl/fetch_decode_if.sv */
`timescale 1ns/1ns

interface fetch_decode_if;

	logic valid;
	logic ready;
	rv_pkg::addr_t pc;
	rv_pkg::inst_t inst;

	modport source (
		output valid, pc, inst,
		input ready
	);

	modport sink (
		input valid, pc, inst,
		output ready
	);

endinterface

/* hdl/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit (
	input logic clock,
	input logic reset,
	input logic imem_ready_i,
	input rv_pkg::inst_t imem_data_i,
	input logic commit_valid_i,
	input rv_pkg::addr_t next_pc_i,
	output logic imem_valid_o,
	output rv_pkg::addr_t imem_addr_o,
	fetch_decode_if.source fd
);

	typedef enum logic {
		FETCH,
		WAIT_COMMIT
	} state_e;

	state_e state_q;
	rv_pkg::addr_t pc_q;
	logic imem_fire;

	assign imem_valid_o = (state_q == FETCH);
	assign imem_addr_o = pc_q;
	assign imem_fire = imem_valid_o && imem_ready_i;

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= FETCH;
			pc_q <= rv_pkg::RESET_PC;
			fd.valid <= 1'b0;
		end else begin
			case (state_q)
				FETCH: begin
					if (imem_fire) begin
						state_q <= WAIT_COMMIT;
					end
				end
				WAIT_COMMIT: begin
					// hold off until the instruction retires
					if (commit_valid_i) begin
						pc_q <= next_pc_i;
						state_q <= FETCH;
					end
				end
				default: state_q <= FETCH;
			endcase

			if (imem_fire) begin
				fd.valid <= 1'b1;
			end else if (fd.ready) begin
				fd.valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (imem_fire) begin
			fd.pc <= pc_q;
			fd.inst <= imem_data_i; // sampled on the handshake edge
		end
	end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
	input logic clock,
	input logic reset,
	input rv_pkg::reg_addr_t rs1_addr_i,
	input rv_pkg::reg_addr_t rs2_addr_i,
	input logic we_i,
	input rv_pkg::reg_addr_t rd_addr_i,
	input rv_pkg::xlen_t rd_data_i,
	output rv_pkg::xlen_t rs1_data_o,
	output rv_pkg::xlen_t rs2_data_o
);

	rv_pkg::xlen_t regs [1:31]; // x0 has no storage

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && (rd_addr_i != '0)) begin
			regs[rd_addr_i] <= rd_data_i;
		end
	end

	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

/* hdl/rv_core.sv */
`timescale 1ns/1ns

module rv_core (
	input logic clock,
	input logic reset,
	output logic imem_valid_o,
	output rv_pkg::addr_t imem_addr_o,
	input logic imem_ready_i,
	input rv_pkg::inst_t imem_data_i,
	output logic commit_valid_o,
	output rv_pkg::addr_t commit_pc_o,
	output rv_pkg::inst_t commit_inst_o,
	output logic commit_we_o,
	output rv_pkg::reg_addr_t commit_rd_o,
	output rv_pkg::xlen_t commit_data_o
);

	rv_pkg::addr_t next_pc;
	rv_pkg::reg_addr_t rs1_addr;
	rv_pkg::reg_addr_t rs2_addr;
	rv_pkg::xlen_t rs1_data;
	rv_pkg::xlen_t rs2_data;

	fetch_decode_if fd_if ();
	decode_execute_if de_if ();

	fetch_unit i_fetch_unit (
		.clock          (clock),
		.reset          (reset),
		.imem_ready_i   (imem_ready_i),
		.imem_data_i    (imem_data_i),
		.commit_valid_i (commit_valid_o), // retire releases the next fetch
		.next_pc_i      (next_pc),
		.imem_valid_o   (imem_valid_o),
		.imem_addr_o    (imem_addr_o),
		.fd             (fd_if.source)
	);

	decode_unit i_decode_unit (
		.clock      (clock),
		.reset      (reset),
		.fd         (fd_if.sink),
		.de         (de_if.source),
		.rs1_addr_o (rs1_addr),
		.rs2_addr_o (rs2_addr),
		.rs1_val_i  (rs1_data),
		.rs2_val_i  (rs2_data)
	);

	reg_file i_reg_file (
		.clock      (clock),
		.reset      (reset),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.we_i       (commit_we_o),
		.rd_addr_i  (commit_rd_o),
		.rd_data_i  (commit_data_o),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data)
	);

	execute_unit i_execute_unit (
		.clock          (clock),
		.reset          (reset),
		.de             (de_if.sink),
		.commit_valid_o (commit_valid_o),
		.commit_pc_o    (commit_pc_o),
		.commit_inst_o  (commit_inst_o),
		.commit_we_o    (commit_we_o),
		.commit_rd_o    (commit_rd_o),
		.commit_data_o  (commit_data_o),
		.next_pc_o      (next_pc)
	);

endmodule

/* hdl/rv_pkg.sv */
package rv_pkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;
	localparam int OPCODE_W = 7;

	typedef logic [XLEN-1:0] xlen_t;
	typedef logic [XLEN-1:0] addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [OPCODE_W-1:0] opcode_t;

	// major opcodes, inst[6:0]
	localparam opcode_t OPC_OP = 7'b0110011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_LUI = 7'b0110111;
	localparam opcode_t OPC_AUIPC = 7'b0010111;
	localparam opcode_t OPC_JAL = 7'b1101111;
	localparam opcode_t OPC_JALR = 7'b1100111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_SLL = 4'd2,
		ALU_SLT = 4'd3,
		ALU_SLTU = 4'd4,
		ALU_XOR = 4'd5,
		ALU_SRL = 4'd6,
		ALU_SRA = 4'd7,
		ALU_OR = 4'd8,
		ALU_AND = 4'd9,
		ALU_PASS_B = 4'd10 // lui
	} alu_op_e;

	typedef enum logic [3:0] {
		BR_NONE = 4'd0,
		BR_EQ = 4'd1,
		BR_NE = 4'd2,
		BR_LT = 4'd3,
		BR_GE = 4'd4,
		BR_LTU = 4'd5,
		BR_GEU = 4'd6,
		BR_JAL = 4'd7,
		BR_JALR = 4'd8
	} br_op_e;

	typedef enum logic {
		SRC_A_RS1 = 1'b0,
		SRC_A_PC = 1'b1
	} src_a_e;

	localparam addr_t RESET_PC = 32'h0000_0000;
	localparam addr_t INST_BYTES = 32'd4;

endpackage
